// File: logic/audio_pkg.sv
/*
 * Audio mixer shared definitions: sample types, boost mode and
 * the constants of the soft-knee compressor
 */
`default_nettype none

package audio_pkg;

	//////////////////////////////////////////////////
	// Sample formats
	//////////////////////////////////////////////////

	// Signed 16-bit audio sample
	typedef logic signed [15:0] sample_t;

	// Signed 18-bit sum, room for four 16-bit terms
	typedef logic signed [17:0] mix_t;

	// Master boost setting, 3 behaves as 4x
	typedef enum logic [1:0] {
		BOOST_NONE = 2'd0,
		BOOST_2X   = 2'd1,
		BOOST_4X   = 2'd2
	} boost_t;

	//////////////////////////////////////////////////
	// Compressor constants
	//////////////////////////////////////////////////

	// 2x: slope 2 below the knee, 1/4 above it
	localparam logic [15:0] COMP_A1 = 16'd2;
	localparam logic [15:0] COMP_F1 = 16'd4;
	// Knee at 32767*3/7 + 1 = 14044
	localparam logic [15:0] COMP_X1 =
		16'((32767 * (COMP_F1 - 16'd1)) / (COMP_F1 * COMP_A1 - 16'd1) + 1);
	// Output level at the knee, 28088
	localparam logic [15:0] COMP_B1 = 16'(COMP_X1 * COMP_A1);

	// 4x: slope 4 below the knee, 1/8 above it
	localparam logic [15:0] COMP_A2 = 16'd4;
	localparam logic [15:0] COMP_F2 = 16'd8;
	// Knee at 32767*7/31 + 1 = 7400
	localparam logic [15:0] COMP_X2 =
		16'((32767 * (COMP_F2 - 16'd1)) / (COMP_F2 * COMP_A2 - 16'd1) + 1);
	// Output level at the knee, 29600
	localparam logic [15:0] COMP_B2 = 16'(COMP_X2 * COMP_A2);

endpackage

`default_nettype wire

// File: logic/source_sum.sv
/*
 * Mixer stage 1: adds the enabled CD, tone generator and ADPCM sources
 * per channel into 18-bit sums, with the CD term doubled on CD boost
 */
`timescale 1ns/10ps
`default_nettype none

module source_sum (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  sample_valid,
	input  wire audio_pkg::sample_t cdda_l,
	input  wire audio_pkg::sample_t cdda_r,
	input  wire audio_pkg::sample_t psg_l,
	input  wire audio_pkg::sample_t psg_r,
	input  wire audio_pkg::sample_t adpcm,
	input  wire                  cdda_en,
	input  wire                  psg_en,
	input  wire                  adpcm_en,
	input  wire                  cd_boost,
	output logic                 sum_valid,
	output audio_pkg::mix_t      sum_l,
	output audio_pkg::mix_t      sum_r
);
	import audio_pkg::*;

	// Sign-extended source terms, zero when disabled
	mix_t cd_term_l;
	mix_t cd_term_r;
	mix_t psg_term_l;
	mix_t psg_term_r;
	mix_t adpcm_term;
	mix_t next_l;
	mix_t next_r;

	always_comb begin
		cd_term_l  = cdda_en ? mix_t'(cdda_l) : '0;
		cd_term_r  = cdda_en ? mix_t'(cdda_r) : '0;
		psg_term_l = psg_en ? mix_t'(psg_l) : '0;
		psg_term_r = psg_en ? mix_t'(psg_r) : '0;
		// Mono speech feeds both channels
		adpcm_term = adpcm_en ? mix_t'(adpcm) : '0;
	end

	// CD counts twice on boost, already zero when disabled
	always_comb begin
		next_l = cd_term_l + psg_term_l + adpcm_term;
		next_r = cd_term_r + psg_term_r + adpcm_term;
		if (cd_boost) begin
			next_l = next_l + cd_term_l;
			next_r = next_r + cd_term_r;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sum_valid <= 1'b0;
			sum_l     <= '0;
			sum_r     <= '0;
		end else begin
			sum_valid <= sample_valid;
			if (sample_valid) begin
				sum_l <= next_l;
				sum_r <= next_r;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/level_scale.sv
/*
 * Mixer stage 2: headroom scaling of the 18-bit sums and cut back to
 * 16-bit samples
 */
`timescale 1ns/10ps
`default_nettype none

module level_scale (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  sum_valid,
	input  wire audio_pkg::mix_t sum_l,
	input  wire audio_pkg::mix_t sum_r,
	input  wire                  cd_boost,
	output logic                 level_valid,
	output audio_pkg::sample_t   level_l,
	output audio_pkg::sample_t   level_r
);
	import audio_pkg::*;

	// Without CD boost the sum gets a quarter added, 3/4 + 1/4 of full range
	function automatic sample_t scale_channel(input mix_t sum, input logic boost);
		mix_t scaled;
		scaled = sum;
		if (!boost)
			scaled = sum + (sum >>> 2);
		// Top 16 of the 18 bits
		return sample_t'(scaled[17:2]);
	endfunction

	sample_t next_l;
	sample_t next_r;

	assign next_l = scale_channel(sum_l, cd_boost);
	assign next_r = scale_channel(sum_r, cd_boost);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			level_valid <= 1'b0;
			level_l     <= '0;
			level_r     <= '0;
		end else begin
			level_valid <= sum_valid;
			if (sum_valid) begin
				level_l <= next_l;
				level_r <= next_r;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/soft_compressor.sv
/*
 * Mixer stage 3: optional master boost through a piecewise-linear
 * soft-knee compressor, 2x or 4x, on both channels
 */
`timescale 1ns/10ps
`default_nettype none

module soft_compressor (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     level_valid,
	input  wire audio_pkg::sample_t level_l,
	input  wire audio_pkg::sample_t level_r,
	input  wire audio_pkg::boost_t  master_boost,
	output logic                    audio_valid,
	output audio_pkg::sample_t      audio_l,
	output audio_pkg::sample_t      audio_r
);
	import audio_pkg::*;

	//////////////////////////////////////////////////
	// Knee parameters for the selected boost
	//////////////////////////////////////////////////

	logic [15:0] knee_x;
	logic [15:0] knee_b;
	logic [15:0] slope_a;
	logic [15:0] fall_f;

	// 2x has its own set, 4x and the spare code share the other
	always_comb begin
		if (master_boost == BOOST_2X) begin
			knee_x  = COMP_X1;
			knee_b  = COMP_B1;
			slope_a = COMP_A1;
			fall_f  = COMP_F1;
		end else begin
			knee_x  = COMP_X2;
			knee_b  = COMP_B2;
			slope_a = COMP_A2;
			fall_f  = COMP_F2;
		end
	end

	//////////////////////////////////////////////////
	// Per-channel transfer curve
	//////////////////////////////////////////////////

	function automatic sample_t compress(
		input sample_t     s,
		input logic [15:0] x,
		input logic [15:0] b,
		input logic [15:0] a,
		input logic [15:0] f
	);
		logic [15:0] mag;
		logic [15:0] res;
		// Magnitude, -32768 maps to 32768
		mag = unsigned'(s);
		if (s[15])
			mag = ~mag + 16'd1;
		if (mag < x)
			res = mag * a;
		else
			res = ((mag - x) / f) + b;
		// Sign restored, wraps in 16 bits
		if (s[15])
			res = ~res + 16'd1;
		return sample_t'(res);
	endfunction

	sample_t next_l;
	sample_t next_r;

	always_comb begin
		next_l = level_l;
		next_r = level_r;
		if (master_boost != BOOST_NONE) begin
			next_l = compress(level_l, knee_x, knee_b, slope_a, fall_f);
			next_r = compress(level_r, knee_x, knee_b, slope_a, fall_f);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_valid <= 1'b0;
			audio_l     <= '0;
			audio_r     <= '0;
		end else begin
			audio_valid <= level_valid;
			if (level_valid) begin
				audio_l <= next_l;
				audio_r <= next_r;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/audio_mixer.sv
/*
 * Three-stage audio mixer: source sum, level scaling and soft
 * compression, three cycles from sample_valid to audio_valid
 */
`timescale 1ns/10ps
`default_nettype none

module audio_mixer (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     sample_valid,
	input  wire audio_pkg::sample_t cdda_l,
	input  wire audio_pkg::sample_t cdda_r,
	input  wire audio_pkg::sample_t psg_l,
	input  wire audio_pkg::sample_t psg_r,
	input  wire audio_pkg::sample_t adpcm,
	input  wire                     cdda_en,
	input  wire                     psg_en,
	input  wire                     adpcm_en,
	input  wire                     cd_boost,
	input  wire audio_pkg::boost_t  master_boost,
	output wire audio_pkg::sample_t audio_l,
	output wire audio_pkg::sample_t audio_r,
	output wire                     audio_valid
);
	import audio_pkg::*;

	// Stage 1 to stage 2
	wire       sum_valid;
	wire mix_t sum_l;
	wire mix_t sum_r;

	// Stage 2 to stage 3
	wire          level_valid;
	wire sample_t level_l;
	wire sample_t level_r;

	source_sum u_source_sum (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sample_valid (sample_valid),
		.cdda_l       (cdda_l),
		.cdda_r       (cdda_r),
		.psg_l        (psg_l),
		.psg_r        (psg_r),
		.adpcm        (adpcm),
		.cdda_en      (cdda_en),
		.psg_en       (psg_en),
		.adpcm_en     (adpcm_en),
		.cd_boost     (cd_boost),
		.sum_valid    (sum_valid),
		.sum_l        (sum_l),
		.sum_r        (sum_r)
	);

	level_scale u_level_scale (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.sum_valid   (sum_valid),
		.sum_l       (sum_l),
		.sum_r       (sum_r),
		.cd_boost    (cd_boost),
		.level_valid (level_valid),
		.level_l     (level_l),
		.level_r     (level_r)
	);

	soft_compressor u_soft_compressor (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.level_valid  (level_valid),
		.level_l      (level_l),
		.level_r      (level_r),
		.master_boost (master_boost),
		.audio_valid  (audio_valid),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

endmodule

`default_nettype wire

// File: sim/mixer_checks.svh
/*
 * Result checks for the audio mixer testbench: compare tasks for
 * samples and valid counts, plus error and vector counters
 */
`ifndef MIXER_CHECKS_SVH
`define MIXER_CHECKS_SVH

// Failed compares, and finished vectors by outcome
int error_count = 0;
int pass_count  = 0;
int fail_count  = 0;

// Compare one output sample against its expected value
task automatic check_sample(input string name, input sample_t exp, input sample_t got);
	if (got !== exp) begin
		$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
		error_count = error_count + 1;
	end
endtask

// Compare a count of audio_valid pulses
task automatic check_valid_count(input string name, input int exp, input int got);
	if (got != exp) begin
		$display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, got);
		error_count = error_count + 1;
	end
endtask

// One result line per finished vector
task automatic report_vector(input int idx, input int errors_before);
	if (error_count == errors_before) begin
		pass_count = pass_count + 1;
		$display("vector %0d passed at %0t", idx, $time);
	end else begin
		fail_count = fail_count + 1;
		$display("vector %0d failed at %0t", idx, $time);
	end
endtask

`endif

// File: sim/audio_mixer_tb.sv
/*
 * Testbench for the three-stage audio mixer with file-driven vectors,
 * in-order result checks with latency tracking and a watchdog
 */
`timescale 1ns/10ps
`default_nettype none

module audio_mixer_tb;
	import audio_pkg::*;

	`include "mixer_checks.svh"

	localparam int MAX_VECTORS = 64;
	localparam int NUM_FIELDS  = 13;
	localparam int PIPE_DEPTH  = 3;
	localparam int IDLE_CYCLES = 3;
	localparam int CLK_PERIOD  = 10;

	logic    clk_sys;
	logic    reset;
	logic    sample_valid;
	sample_t cdda_l;
	sample_t cdda_r;
	sample_t psg_l;
	sample_t psg_r;
	sample_t adpcm;
	logic    cdda_en;
	logic    psg_en;
	logic    adpcm_en;
	logic    cd_boost;
	boost_t  master_boost;
	sample_t audio_l;
	sample_t audio_r;
	logic    audio_valid;

	// Samples, enables, cd_boost, master_boost, expected l/r, gap
	int   vectors [MAX_VECTORS][NUM_FIELDS];
	int   vec_count = 0;
	logic load_done = 1'b0;

	// Sets in flight with the oldest first
	sample_t exp_l_q [$];
	sample_t exp_r_q [$];
	int      launch_q [$];
	int      index_q [$];

	int cycle      = 0;
	int valid_seen = 0;

	audio_mixer dut0 (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sample_valid (sample_valid),
		.cdda_l       (cdda_l),
		.cdda_r       (cdda_r),
		.psg_l        (psg_l),
		.psg_r        (psg_r),
		.adpcm        (adpcm),
		.cdda_en      (cdda_en),
		.psg_en       (psg_en),
		.adpcm_en     (adpcm_en),
		.cd_boost     (cd_boost),
		.master_boost (master_boost),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.audio_valid  (audio_valid)
	);

	initial clk_sys = 1'b0;
	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// Edge count for the latency check
	always @(posedge clk_sys) cycle <= cycle + 1;

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic read_vectors();
		int    fd;
		int    n;
		string line;
		fd = $fopen("sim/audio_mixer_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test vector file");
		end else begin
			while (!$feof(fd) && vec_count < MAX_VECTORS) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
						vectors[vec_count][0], vectors[vec_count][1],
						vectors[vec_count][2], vectors[vec_count][3],
						vectors[vec_count][4], vectors[vec_count][5],
						vectors[vec_count][6], vectors[vec_count][7],
						vectors[vec_count][8], vectors[vec_count][9],
						vectors[vec_count][10], vectors[vec_count][11],
						vectors[vec_count][12]);
					if (n == NUM_FIELDS) begin
						vec_count = vec_count + 1;
					end else if (n > 0) begin
						$display("Malformed vector line skipped: %s", line);
						error_count = error_count + 1;
					end
				end
			end
			$fclose(fd);
		end
		load_done = 1'b1;
	endtask

	task automatic drive_vector(input int idx);
		@(posedge clk_sys);
		sample_valid <= 1'b1;
		cdda_l       <= vectors[idx][0][15:0];
		cdda_r       <= vectors[idx][1][15:0];
		psg_l        <= vectors[idx][2][15:0];
		psg_r        <= vectors[idx][3][15:0];
		adpcm        <= vectors[idx][4][15:0];
		cdda_en      <= vectors[idx][5][0];
		psg_en       <= vectors[idx][6][0];
		adpcm_en     <= vectors[idx][7][0];
		cd_boost     <= vectors[idx][8][0];
		master_boost <= boost_t'(vectors[idx][9][1:0]);
		exp_l_q.push_back(vectors[idx][10][15:0]);
		exp_r_q.push_back(vectors[idx][11][15:0]);
		// Output due three edges after this launch edge
		launch_q.push_back(cycle + 1);
		index_q.push_back(idx);
	endtask

	// Settings stay put while the last set drains
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			sample_valid <= 1'b0;
		end
	endtask

	task automatic finish_run();
		$display("Vectors passed: %0d, vectors failed: %0d, check errors: %0d",
			pass_count, fail_count, error_count);
		if (error_count == 0 && fail_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	endtask

	initial begin : main_seq
		int i;
		int errors_before;
		reset        = 1'b1;
		sample_valid = 1'b0;
		cdda_l       = '0;
		cdda_r       = '0;
		psg_l        = '0;
		psg_r        = '0;
		adpcm        = '0;
		cdda_en      = 1'b0;
		psg_en       = 1'b0;
		adpcm_en     = 1'b0;
		cd_boost     = 1'b0;
		master_boost = BOOST_NONE;
		read_vectors();
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;

		// Outputs stay cleared until the first set arrives
		errors_before = error_count;
		repeat (PIPE_DEPTH) begin
			@(negedge clk_sys);
			check_sample("audio_l", '0, audio_l);
			check_sample("audio_r", '0, audio_r);
		end
		@(posedge clk_sys);
		check_valid_count("audio_valid count after reset", 0, valid_seen);
		if (error_count == errors_before) begin
			$display("reset check passed at %0t", $time);
		end else begin
			$display("reset check failed at %0t", $time);
		end

		if (vec_count == 0) begin
			$display("No test vectors were loaded");
			error_count = error_count + 1;
		end else begin
			for (i = 0; i < vec_count; i++) begin
				drive_vector(i);
				if (vectors[i][12] != 0) begin
					idle_cycles(IDLE_CYCLES);
				end
			end
			idle_cycles(1);
			while (launch_q.size() > 0) begin
				@(negedge clk_sys);
			end
			// A few spare cycles to catch stray valids
			repeat (PIPE_DEPTH + 1) @(posedge clk_sys);
			check_valid_count("audio_valid count", vec_count, valid_seen);
		end
		finish_run();
	end

	//////////////////////////////////////////////////
	// Result monitor and watchdog
	//////////////////////////////////////////////////

	always @(negedge clk_sys) begin : monitor
		int idx;
		int launch;
		int errors_before;
		if (!reset) begin
			if (audio_valid) begin
				valid_seen = valid_seen + 1;
				if (index_q.size() == 0) begin
					$display("Unexpected audio_valid at %0t with no sample set in flight",
						$time);
					error_count = error_count + 1;
				end else begin
					errors_before = error_count;
					idx = index_q.pop_front();
					launch = launch_q.pop_front();
					if (cycle != launch + PIPE_DEPTH) begin
						$display("Vector %0d came out %0d cycles after sample_valid, not %0d",
							idx, cycle - launch, PIPE_DEPTH);
						error_count = error_count + 1;
					end
					check_sample("audio_l", exp_l_q.pop_front(), audio_l);
					check_sample("audio_r", exp_r_q.pop_front(), audio_r);
					report_vector(idx, errors_before);
				end
			end else if (launch_q.size() > 0 && cycle >= launch_q[0] + PIPE_DEPTH) begin
				// Overdue set that never came out
				errors_before = error_count;
				idx = index_q.pop_front();
				launch_q.delete(0);
				exp_l_q.delete(0);
				exp_r_q.delete(0);
				$display("Vector %0d got no audio_valid %0d cycles after sample_valid",
					idx, PIPE_DEPTH);
				error_count = error_count + 1;
				report_vector(idx, errors_before);
			end
		end
	end

	initial begin : watchdog
		wait (load_done);
		#((vec_count * 4 + 20) * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", vec_count * 4 + 20);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/audio_mixer_tests.txt
# cdda_l cdda_r psg_l psg_r adpcm cdda_en psg_en adpcm_en cd_boost master_boost exp_l exp_r gap
# All hex; gap 0 means the next vector follows back to back, 1 means idle cycles follow
1000 F000 0800 0400 0200 1 1 1 0 0 0820 FCE0 0
7FFF 8000 7FFF 8000 0001 1 1 1 0 0 4FFF B000 0
1000 F000 0800 0400 0200 0 1 1 0 0 0320 01E0 0
1000 F000 0800 0400 0200 1 0 1 0 0 05A0 FBA0 0
1000 F000 0800 0400 0200 1 1 0 0 0 0780 FC40 0
1000 F000 0800 0400 0200 0 0 0 0 0 0000 0000 1
8000 7FFF 0000 0000 0000 1 1 1 1 0 C000 3FFF 0
8000 8000 8000 7FFF 8000 1 1 1 1 0 8000 BFFF 0
7FFF 7FFF 0100 0200 0003 0 1 1 1 0 0040 0080 1
6DB6 9248 0000 0000 0000 1 1 1 1 1 6DB6 9248 0
7FFF 8000 7FFF 8000 7FFF 1 1 1 1 1 8000 8FFF 0
8000 0000 8000 0000 8000 1 1 1 1 1 7FFF C000 1
39CE C630 0000 0000 0000 1 1 1 1 2 739C 8C60 0
7FFF 8000 7FFF 8000 7FFF 1 1 1 1 2 8002 87FD 1
8000 0000 8000 0000 8000 1 1 1 1 3 7FFD 8BFD 0
0800 F800 0000 0000 0000 1 1 1 1 3 1000 F000 1

// File: project.f
+incdir+sim
logic/audio_pkg.sv
logic/source_sum.sv
logic/level_scale.sv
logic/soft_compressor.sv
logic/audio_mixer.sv
sim/audio_mixer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the audio mixer testbench with Verilator and runs it.
# Exit status is zero only when the run prints the pass message.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot change to the project directory"
	exit 1
fi

command -v verilator > /dev/null 2>&1
if [ $? -ne 0 ]; then
	echo "verilator was not found on the PATH"
	exit 1
fi

verilator --binary --timing --timescale 1ns/10ps \
	-f project.f --top-module audio_mixer_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vaudio_mixer_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "$output" | grep -qx "Test OK"
if [ $? -ne 0 ]; then
	exit 1
fi
exit 0
